// ==== src/lc4_core_pkg.sv ====
package lc4_core_pkg;

    localparam int WORD_W   = 16;
    localparam int NUM_REGS = 8;
    localparam int REG_W    = 3;

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [REG_W-1:0]  reg_idx_t;
    typedef logic [2:0]        nzp_t;

    // condition codes, one-hot
    localparam nzp_t NZP_N = 3'b100;
    localparam nzp_t NZP_Z = 3'b010;
    localparam nzp_t NZP_P = 3'b001;

endpackage

// ==== src/lc4_isa_pkg.sv ====
package lc4_isa_pkg;

    // field widths of a 16-bit LC4 word
    localparam int OPC_W  = 4;
    localparam int SUB_W  = 3;
    localparam int IMM5_W = 5;
    localparam int IMM9_W = 9;

    // opcodes kept in the ALU-only subset
    localparam logic [OPC_W-1:0] OP_ARITH = 4'b0001;
    localparam logic [OPC_W-1:0] OP_LOGIC = 4'b0101;
    localparam logic [OPC_W-1:0] OP_CONST = 4'b1001;

    // sub-op codes at bits 5..3, bit 5 set means immediate form
    localparam logic [SUB_W-1:0] SUB_ADD = 3'b000;
    localparam logic [SUB_W-1:0] SUB_SUB = 3'b010;
    localparam logic [SUB_W-1:0] SUB_AND = 3'b000;
    localparam logic [SUB_W-1:0] SUB_NOT = 3'b001;
    localparam logic [SUB_W-1:0] SUB_OR  = 3'b010;
    localparam logic [SUB_W-1:0] SUB_XOR = 3'b011;

    typedef struct packed {
        logic [OPC_W-1:0]       opcode;
        lc4_core_pkg::reg_idx_t rd;
        lc4_core_pkg::reg_idx_t rs;
        logic [SUB_W-1:0]       sub;
        lc4_core_pkg::reg_idx_t rt;
    } insn_rrr_t;

    typedef struct packed {
        logic [OPC_W-1:0]       opcode;
        lc4_core_pkg::reg_idx_t rd;
        lc4_core_pkg::reg_idx_t rs;
        logic                   imm_flag;
        logic [IMM5_W-1:0]      imm;
    } insn_imm5_t;

    typedef struct packed {
        logic [OPC_W-1:0]       opcode;
        lc4_core_pkg::reg_idx_t rd;
        logic [IMM9_W-1:0]      imm;
    } insn_imm9_t;

    // one instruction word, three views of its low bits
    typedef union packed {
        insn_rrr_t  rrr;
        insn_imm5_t imm5;
        insn_imm9_t imm9;
    } insn_t;

    // true for every encoding that writes rd, all others are NOPs
    function automatic logic writes_reg(insn_t insn);
        logic w;
        case (insn.rrr.opcode)
            OP_ARITH: w = insn.imm5.imm_flag || (insn.rrr.sub == SUB_ADD)
                          || (insn.rrr.sub == SUB_SUB);
            // and, not, or, xor and the immediate and fill every logic code
            OP_LOGIC: w = 1'b1;
            OP_CONST: w = 1'b1;
            default:  w = 1'b0;
        endcase
        return w;
    endfunction

endpackage

// ==== src/lc4_regfile_2w.sv ====
`timescale 1ns/100ps

module lc4_regfile_2w (
    input  logic                   gwe,
    input  logic                   i_reset,
    input  lc4_core_pkg::reg_idx_t i_rs_sel_a,
    input  lc4_core_pkg::reg_idx_t i_rt_sel_a,
    input  lc4_core_pkg::reg_idx_t i_rs_sel_b,
    input  lc4_core_pkg::reg_idx_t i_rt_sel_b,
    output lc4_core_pkg::word_t    o_rs_data_a,
    output lc4_core_pkg::word_t    o_rt_data_a,
    output lc4_core_pkg::word_t    o_rs_data_b,
    output lc4_core_pkg::word_t    o_rt_data_b,
    input  logic                   i_we_a,
    input  logic                   i_we_b,
    input  lc4_core_pkg::reg_idx_t i_wsel_a,
    input  lc4_core_pkg::reg_idx_t i_wsel_b,
    input  lc4_core_pkg::word_t    i_wdata_a,
    input  lc4_core_pkg::word_t    i_wdata_b
);
    import lc4_core_pkg::*;

    word_t regs [NUM_REGS];

    always_ff @(posedge gwe) begin
        if (i_reset) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (i_we_a) begin
                regs[i_wsel_a] <= i_wdata_a;
            end
            // port b is the younger write
            if (i_we_b) begin
                regs[i_wsel_b] <= i_wdata_b;
            end
        end
    end

    // reads see the value before this cycle's writes
    assign o_rs_data_a = regs[i_rs_sel_a];
    assign o_rt_data_a = regs[i_rt_sel_a];
    assign o_rs_data_b = regs[i_rs_sel_b];
    assign o_rt_data_b = regs[i_rt_sel_b];

    a_write_ports_distinct: assert property (@(posedge gwe) disable iff (i_reset)
        !(i_we_a && i_we_b && (i_wsel_a == i_wsel_b)))
        else $error("both write ports target register %0d", i_wsel_a);

endmodule

// ==== src/lc4_alu_lane.sv ====
`timescale 1ns/100ps

module lc4_alu_lane (
    input  logic                   i_valid,
    input  lc4_isa_pkg::insn_t     i_insn,
    input  lc4_core_pkg::word_t    i_rs,
    input  lc4_core_pkg::word_t    i_rt,
    output lc4_core_pkg::word_t    o_result,
    output logic                   o_we,
    output lc4_core_pkg::reg_idx_t o_wsel
);
    import lc4_core_pkg::*;
    import lc4_isa_pkg::*;

    word_t imm5_ext;
    word_t imm9_ext;

    // sign-extended immediates
    assign imm5_ext = {{(WORD_W-IMM5_W){i_insn.imm5.imm[IMM5_W-1]}}, i_insn.imm5.imm};
    assign imm9_ext = {{(WORD_W-IMM9_W){i_insn.imm9.imm[IMM9_W-1]}}, i_insn.imm9.imm};

    always_comb begin
        o_result = '0;
        case (i_insn.rrr.opcode)
            OP_ARITH: begin
                if (i_insn.imm5.imm_flag) begin
                    o_result = i_rs + imm5_ext;
                end else begin
                    case (i_insn.rrr.sub)
                        SUB_ADD: o_result = i_rs + i_rt;
                        SUB_SUB: o_result = i_rs - i_rt;
                        default: o_result = '0;
                    endcase
                end
            end
            OP_LOGIC: begin
                if (i_insn.imm5.imm_flag) begin
                    o_result = i_rs & imm5_ext;
                end else begin
                    case (i_insn.rrr.sub)
                        SUB_AND: o_result = i_rs & i_rt;
                        SUB_NOT: o_result = ~i_rs;
                        SUB_OR:  o_result = i_rs | i_rt;
                        SUB_XOR: o_result = i_rs ^ i_rt;
                        default: o_result = '0;
                    endcase
                end
            end
            OP_CONST: o_result = imm9_ext;
            default:  o_result = '0;
        endcase
    end

    // an empty lane or a nop never writes
    assign o_we   = i_valid && writes_reg(i_insn);
    assign o_wsel = i_insn.rrr.rd;

endmodule

// ==== src/lc4_pair_issue.sv ====
`timescale 1ns/100ps

module lc4_pair_issue (
    input  logic                   gwe,
    input  logic                   i_reset,
    input  logic                   i_pair_valid,
    output logic                   o_pair_ready,
    input  lc4_isa_pkg::insn_t     i_insn_a,
    input  lc4_isa_pkg::insn_t     i_insn_b,
    output lc4_core_pkg::reg_idx_t o_rd_rs_a,
    output lc4_core_pkg::reg_idx_t o_rd_rt_a,
    output lc4_core_pkg::reg_idx_t o_rd_rs_b,
    output lc4_core_pkg::reg_idx_t o_rd_rt_b,
    input  lc4_core_pkg::word_t    i_rf_rs_a,
    input  lc4_core_pkg::word_t    i_rf_rt_a,
    input  lc4_core_pkg::word_t    i_rf_rs_b,
    input  lc4_core_pkg::word_t    i_rf_rt_b,
    input  lc4_core_pkg::word_t    i_res_a,
    input  lc4_core_pkg::word_t    i_res_b,
    input  logic                   i_we_a,
    input  logic                   i_we_b,
    input  lc4_core_pkg::reg_idx_t i_wsel_a,
    input  lc4_core_pkg::reg_idx_t i_wsel_b,
    output logic                   o_x_valid_a,
    output logic                   o_x_valid_b,
    output lc4_isa_pkg::insn_t     o_x_insn_a,
    output lc4_isa_pkg::insn_t     o_x_insn_b,
    output lc4_core_pkg::word_t    o_x_rs_a,
    output lc4_core_pkg::word_t    o_x_rt_a,
    output lc4_core_pkg::word_t    o_x_rs_b,
    output lc4_core_pkg::word_t    o_x_rt_b
);
    import lc4_core_pkg::*;
    import lc4_isa_pkg::*;

    logic  run_q;
    logic  split_q;
    logic  pair_dep;
    logic  split_first;
    word_t op_rs_a;
    word_t op_rt_a;
    word_t op_rs_b;
    word_t op_rt_b;

    // b reads a register that a writes in the same pair
    function automatic logic needs_split(insn_t a, insn_t b);
        logic b_alu;
        logic rs_hit;
        logic rt_hit;
        b_alu  = (b.rrr.opcode == OP_ARITH) || (b.rrr.opcode == OP_LOGIC);
        rs_hit = b_alu && (b.rrr.rs == a.rrr.rd);
        rt_hit = b_alu && !b.imm5.imm_flag && (b.rrr.rt == a.rrr.rd);
        return writes_reg(a) && (rs_hit || rt_hit);
    endfunction

    // mx bypass, the younger lane b result wins
    function automatic word_t forward(reg_idx_t sel, word_t rf_data);
        if (i_we_b && (i_wsel_b == sel)) begin
            return i_res_b;
        end else if (i_we_a && (i_wsel_a == sel)) begin
            return i_res_a;
        end
        return rf_data;
    endfunction

    assign pair_dep     = needs_split(i_insn_a, i_insn_b);
    assign split_first  = i_pair_valid && run_q && !split_q && pair_dep;
    assign o_pair_ready = run_q && !split_first;

    assign o_rd_rs_a = i_insn_a.rrr.rs;
    assign o_rd_rt_a = i_insn_a.rrr.rt;
    assign o_rd_rs_b = i_insn_b.rrr.rs;
    assign o_rd_rt_b = i_insn_b.rrr.rt;

    always_comb begin
        op_rs_a = forward(i_insn_a.rrr.rs, i_rf_rs_a);
        op_rt_a = forward(i_insn_a.rrr.rt, i_rf_rt_a);
        op_rs_b = forward(i_insn_b.rrr.rs, i_rf_rs_b);
        op_rt_b = forward(i_insn_b.rrr.rt, i_rf_rt_b);
    end

    // first half of a split sends a alone, second half sends b alone
    always_ff @(posedge gwe) begin
        if (i_reset) begin
            run_q       <= 1'b0;
            split_q     <= 1'b0;
            o_x_valid_a <= 1'b0;
            o_x_valid_b <= 1'b0;
        end else begin
            run_q       <= 1'b1;
            split_q     <= split_first;
            o_x_valid_a <= split_first || (i_pair_valid && o_pair_ready && !split_q);
            o_x_valid_b <= i_pair_valid && o_pair_ready;
        end
    end

    always_ff @(posedge gwe) begin
        o_x_insn_a <= i_insn_a;
        o_x_insn_b <= i_insn_b;
        o_x_rs_a   <= op_rs_a;
        o_x_rt_a   <= op_rt_a;
        o_x_rs_b   <= op_rs_b;
        o_x_rt_b   <= op_rt_b;
    end

    a_no_pair_dep: assert property (@(posedge gwe) disable iff (i_reset)
        (o_x_valid_a && o_x_valid_b) |-> !needs_split(o_x_insn_a, o_x_insn_b))
        else $error("issued pair has b reading a's destination");

endmodule

// ==== src/lc4_commit.sv ====
`timescale 1ns/100ps

module lc4_commit (
    input  logic                   gwe,
    input  logic                   i_reset,
    input  logic                   i_valid_a,
    input  logic                   i_valid_b,
    input  lc4_core_pkg::word_t    i_res_a,
    input  lc4_core_pkg::word_t    i_res_b,
    input  logic                   i_we_a,
    input  logic                   i_we_b,
    input  lc4_core_pkg::reg_idx_t i_wsel_a,
    input  lc4_core_pkg::reg_idx_t i_wsel_b,
    output logic                   o_rf_we_a,
    output logic                   o_rf_we_b,
    output lc4_core_pkg::reg_idx_t o_rf_wsel_a,
    output lc4_core_pkg::reg_idx_t o_rf_wsel_b,
    output lc4_core_pkg::word_t    o_rf_wdata_a,
    output lc4_core_pkg::word_t    o_rf_wdata_b,
    output logic                   o_commit_valid_a,
    output logic                   o_commit_valid_b,
    output logic                   o_commit_we_a,
    output logic                   o_commit_we_b,
    output lc4_core_pkg::reg_idx_t o_commit_wsel_a,
    output lc4_core_pkg::reg_idx_t o_commit_wsel_b,
    output lc4_core_pkg::word_t    o_commit_data_a,
    output lc4_core_pkg::word_t    o_commit_data_b,
    output lc4_core_pkg::nzp_t     o_nzp
);
    import lc4_core_pkg::*;

    logic we_a_eff;
    nzp_t nzp_next;

    function automatic nzp_t nzp_of(word_t value);
        if (value[WORD_W-1]) begin
            return NZP_N;
        end else if (value == '0) begin
            return NZP_Z;
        end
        return NZP_P;
    endfunction

    // lane b is younger, so a same-register write from a is dropped
    assign we_a_eff = i_we_a && !(i_we_b && (i_wsel_b == i_wsel_a));

    assign o_rf_we_a    = we_a_eff;
    assign o_rf_we_b    = i_we_b;
    assign o_rf_wsel_a  = i_wsel_a;
    assign o_rf_wsel_b  = i_wsel_b;
    assign o_rf_wdata_a = i_res_a;
    assign o_rf_wdata_b = i_res_b;

    // nzp follows the youngest writer, nops leave it alone
    always_comb begin
        if (i_we_b) begin
            nzp_next = nzp_of(i_res_b);
        end else if (i_we_a) begin
            nzp_next = nzp_of(i_res_a);
        end else begin
            nzp_next = o_nzp;
        end
    end

    always_ff @(posedge gwe) begin
        if (i_reset) begin
            o_commit_valid_a <= 1'b0;
            o_commit_valid_b <= 1'b0;
            o_commit_we_a    <= 1'b0;
            o_commit_we_b    <= 1'b0;
            o_nzp            <= '0;
        end else begin
            o_commit_valid_a <= i_valid_a;
            o_commit_valid_b <= i_valid_b;
            o_commit_we_a    <= we_a_eff;
            o_commit_we_b    <= i_we_b;
            o_nzp            <= nzp_next;
        end
    end

    always_ff @(posedge gwe) begin
        o_commit_wsel_a <= i_wsel_a;
        o_commit_wsel_b <= i_wsel_b;
        o_commit_data_a <= i_res_a;
        o_commit_data_b <= i_res_b;
    end

    a_nzp_onehot: assert property (@(posedge gwe) disable iff (i_reset) $onehot0(o_nzp))
        else $error("nzp register holds %b", o_nzp);

endmodule

// ==== src/lc4_dual_core.sv ====
`timescale 1ns/100ps

module lc4_dual_core (
    input  logic                   gwe,
    input  logic                   i_reset,
    input  logic                   i_pair_valid,
    output logic                   o_pair_ready,
    input  lc4_isa_pkg::insn_t     i_insn_a,
    input  lc4_isa_pkg::insn_t     i_insn_b,
    output logic                   o_commit_valid_a,
    output logic                   o_commit_valid_b,
    output logic                   o_commit_we_a,
    output logic                   o_commit_we_b,
    output lc4_core_pkg::reg_idx_t o_commit_wsel_a,
    output lc4_core_pkg::reg_idx_t o_commit_wsel_b,
    output lc4_core_pkg::word_t    o_commit_data_a,
    output lc4_core_pkg::word_t    o_commit_data_b,
    output lc4_core_pkg::nzp_t     o_nzp
);
    import lc4_core_pkg::*;
    import lc4_isa_pkg::*;

    // register file read side
    reg_idx_t rd_rs_a, rd_rt_a, rd_rs_b, rd_rt_b;
    word_t    rf_rs_a, rf_rt_a, rf_rs_b, rf_rt_b;

    // execute stage
    logic     x_valid_a, x_valid_b;
    insn_t    x_insn_a, x_insn_b;
    word_t    x_rs_a, x_rt_a, x_rs_b, x_rt_b;

    // lane results
    word_t    res_a, res_b;
    logic     we_a, we_b;
    reg_idx_t wsel_a, wsel_b;

    // write ports after ordering
    logic     rf_we_a, rf_we_b;
    reg_idx_t rf_wsel_a, rf_wsel_b;
    word_t    rf_wdata_a, rf_wdata_b;

    lc4_pair_issue issue (
        .gwe(gwe), .i_reset(i_reset), .i_pair_valid(i_pair_valid),
        .o_pair_ready(o_pair_ready), .i_insn_a(i_insn_a), .i_insn_b(i_insn_b),
        .o_rd_rs_a(rd_rs_a), .o_rd_rt_a(rd_rt_a), .o_rd_rs_b(rd_rs_b), .o_rd_rt_b(rd_rt_b),
        .i_rf_rs_a(rf_rs_a), .i_rf_rt_a(rf_rt_a), .i_rf_rs_b(rf_rs_b), .i_rf_rt_b(rf_rt_b),
        .i_res_a(res_a), .i_res_b(res_b), .i_we_a(we_a), .i_we_b(we_b),
        .i_wsel_a(wsel_a), .i_wsel_b(wsel_b),
        .o_x_valid_a(x_valid_a), .o_x_valid_b(x_valid_b),
        .o_x_insn_a(x_insn_a), .o_x_insn_b(x_insn_b),
        .o_x_rs_a(x_rs_a), .o_x_rt_a(x_rt_a), .o_x_rs_b(x_rs_b), .o_x_rt_b(x_rt_b)
    );

    lc4_alu_lane lane_a (
        .i_valid(x_valid_a), .i_insn(x_insn_a), .i_rs(x_rs_a), .i_rt(x_rt_a),
        .o_result(res_a), .o_we(we_a), .o_wsel(wsel_a)
    );

    lc4_alu_lane lane_b (
        .i_valid(x_valid_b), .i_insn(x_insn_b), .i_rs(x_rs_b), .i_rt(x_rt_b),
        .o_result(res_b), .o_we(we_b), .o_wsel(wsel_b)
    );

    lc4_commit commit (
        .gwe(gwe), .i_reset(i_reset), .i_valid_a(x_valid_a), .i_valid_b(x_valid_b),
        .i_res_a(res_a), .i_res_b(res_b), .i_we_a(we_a), .i_we_b(we_b),
        .i_wsel_a(wsel_a), .i_wsel_b(wsel_b),
        .o_rf_we_a(rf_we_a), .o_rf_we_b(rf_we_b),
        .o_rf_wsel_a(rf_wsel_a), .o_rf_wsel_b(rf_wsel_b),
        .o_rf_wdata_a(rf_wdata_a), .o_rf_wdata_b(rf_wdata_b),
        .o_commit_valid_a(o_commit_valid_a), .o_commit_valid_b(o_commit_valid_b),
        .o_commit_we_a(o_commit_we_a), .o_commit_we_b(o_commit_we_b),
        .o_commit_wsel_a(o_commit_wsel_a), .o_commit_wsel_b(o_commit_wsel_b),
        .o_commit_data_a(o_commit_data_a), .o_commit_data_b(o_commit_data_b),
        .o_nzp(o_nzp)
    );

    lc4_regfile_2w regfile (
        .gwe(gwe), .i_reset(i_reset),
        .i_rs_sel_a(rd_rs_a), .i_rt_sel_a(rd_rt_a),
        .i_rs_sel_b(rd_rs_b), .i_rt_sel_b(rd_rt_b),
        .o_rs_data_a(rf_rs_a), .o_rt_data_a(rf_rt_a),
        .o_rs_data_b(rf_rs_b), .o_rt_data_b(rf_rt_b),
        .i_we_a(rf_we_a), .i_we_b(rf_we_b),
        .i_wsel_a(rf_wsel_a), .i_wsel_b(rf_wsel_b),
        .i_wdata_a(rf_wdata_a), .i_wdata_b(rf_wdata_b)
    );

endmodule

// ==== verif/tb_lc4_ref_model.svh ====
`ifndef TB_LC4_REF_MODEL_SVH
`define TB_LC4_REF_MODEL_SVH

// architectural state the core should reach, in program order
word_t       model_regs [NUM_REGS];
nzp_t        model_nzp;
logic [31:0] lcg_state = 32'hd4a6_d0e5;

function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
endfunction

function automatic insn_t rrr_word(logic [3:0] opc, reg_idx_t rd, reg_idx_t rs,
                                   logic [2:0] sub, reg_idx_t rt);
    return {opc, rd, rs, sub, rt};
endfunction

// bit 5 set marks the immediate form
function automatic insn_t imm5_word(logic [3:0] opc, reg_idx_t rd, reg_idx_t rs,
                                    logic [4:0] imm);
    return {opc, rd, rs, 1'b1, imm};
endfunction

function automatic insn_t const_word(reg_idx_t rd, logic [8:0] imm);
    return {OP_CONST, rd, imm};
endfunction

function automatic nzp_t nzp_for(word_t value);
    if (value[15]) begin
        return NZP_N;
    end else if (value == 16'h0000) begin
        return NZP_Z;
    end
    return NZP_P;
endfunction

// result of one instruction against the model registers
function automatic void predict(input insn_t insn, output logic we, output reg_idx_t rd,
                                output word_t res);
    logic [15:0] w;
    word_t       rs_v;
    word_t       rt_v;
    word_t       i5;
    word_t       i9;
    w    = insn;
    rd   = w[11:9];
    rs_v = model_regs[w[8:6]];
    rt_v = model_regs[w[2:0]];
    i5   = {{11{w[4]}}, w[4:0]};
    i9   = {{7{w[8]}}, w[8:0]};
    we   = 1'b1;
    res  = 16'h0000;
    case (w[15:12])
        OP_ARITH: begin
            if (w[5]) begin
                res = rs_v + i5;
            end else begin
                case (w[5:3])
                    3'b000:  res = rs_v + rt_v;
                    3'b010:  res = rs_v - rt_v;
                    // mul, div and mod are gone
                    default: we = 1'b0;
                endcase
            end
        end
        OP_LOGIC: begin
            if (w[5]) begin
                res = rs_v & i5;
            end else begin
                case (w[5:3])
                    3'b000:  res = rs_v & rt_v;
                    3'b001:  res = ~rs_v;
                    3'b010:  res = rs_v | rt_v;
                    default: res = rs_v ^ rt_v;
                endcase
            end
        end
        OP_CONST: res = i9;
        default:  we = 1'b0;
    endcase
endfunction

function automatic void apply_write(logic we, reg_idx_t rd, word_t res);
    if (we) begin
        model_regs[rd] = res;
        model_nzp      = nzp_for(res);
    end
endfunction

// b reads rs, or rt in register form, and a writes that register
function automatic logic b_reads_a_dest(insn_t a, insn_t b);
    logic [15:0] wb;
    logic        a_we;
    reg_idx_t    a_rd;
    word_t       unused;
    logic        b_alu;
    wb = b;
    predict(a, a_we, a_rd, unused);
    b_alu = (wb[15:12] == OP_ARITH) || (wb[15:12] == OP_LOGIC);
    return a_we && b_alu && ((wb[8:6] == a_rd) || (!wb[5] && (wb[2:0] == a_rd)));
endfunction

// legal words only, with nops of two kinds
function automatic insn_t random_insn();
    logic [31:0] r;
    reg_idx_t    rd;
    reg_idx_t    rs;
    reg_idx_t    rt;
    r  = lcg_next();
    rd = r[27:25];
    rs = r[24:22];
    rt = r[21:19];
    case (r[31:28])
        4'd0, 4'd1: return rrr_word(OP_ARITH, rd, rs, SUB_ADD, rt);
        4'd2:       return rrr_word(OP_ARITH, rd, rs, SUB_SUB, rt);
        4'd3:       return imm5_word(OP_ARITH, rd, rs, r[20:16]);
        4'd4:       return rrr_word(OP_LOGIC, rd, rs, SUB_AND, rt);
        4'd5:       return rrr_word(OP_LOGIC, rd, rs, SUB_NOT, rt);
        4'd6:       return rrr_word(OP_LOGIC, rd, rs, SUB_OR, rt);
        4'd7:       return rrr_word(OP_LOGIC, rd, rs, SUB_XOR, rt);
        4'd8:       return imm5_word(OP_LOGIC, rd, rs, r[20:16]);
        4'd12:      return '0;
        4'd13:      return {4'b0110, r[27:16]};
        default:    return const_word(rd, r[24:16]);
    endcase
endfunction

`endif

// ==== verif/tb_lc4_dual_core.sv ====
`timescale 1ns/100ps

module tb_lc4_dual_core;
    import lc4_core_pkg::*;
    import lc4_isa_pkg::*;

    localparam int PERIOD         = 100;
    localparam int DRIVE_DLY      = 5;
    localparam int RESET_CYCLES   = 8;
    localparam int DIRECTED_PAIRS = 20;
    localparam int RANDOM_PAIRS   = 200;
    // a pair needs at most two cycles plus an optional idle one
    localparam int MAX_CYCLES     = RESET_CYCLES + 3 * (DIRECTED_PAIRS + RANDOM_PAIRS) + 100;

    typedef struct {
        int       due;
        logic     valid_a;
        logic     valid_b;
        logic     we_a;
        logic     we_b;
        reg_idx_t wsel_a;
        reg_idx_t wsel_b;
        word_t    data_a;
        word_t    data_b;
        nzp_t     nzp;
    } commit_t;

    logic     gwe;
    logic     i_reset;
    logic     i_pair_valid;
    logic     o_pair_ready;
    insn_t    i_insn_a;
    insn_t    i_insn_b;
    logic     o_commit_valid_a, o_commit_valid_b;
    logic     o_commit_we_a, o_commit_we_b;
    reg_idx_t o_commit_wsel_a, o_commit_wsel_b;
    word_t    o_commit_data_a, o_commit_data_b;
    nzp_t     o_nzp;

    commit_t  exp_q [$];
    int       cycle_count = 0;

    `include "tb_lc4_ref_model.svh"

    lc4_dual_core lc4_dual_core_i (.*);

    initial begin
        gwe = 1'b0;
        forever #(PERIOD / 2) gwe = ~gwe;
    end

    always @(posedge gwe) cycle_count <= cycle_count + 1;

    initial begin : watchdog
        #(MAX_CYCLES * PERIOD);
        $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
        $display("sim failed");
        $fatal(1, "watchdog expired");
    end

    task automatic check_value(string what, logic [31:0] got, logic [31:0] exp);
        if (got !== exp) begin
            $display("[FAIL] time %0t: %s, got %0h, expected %0h", $time, what, got, exp);
            $display("sim failed");
            $fatal(1, "mismatch");
        end
    endtask

    task automatic abort_run(string why);
        $display("error at time %0t: %s", $time, why);
        $display("sim failed");
        $fatal(1, "run aborted");
    endtask

    task automatic compare_commit(commit_t e);
        check_value("commit cycle", cycle_count, e.due);
        check_value("lane a commit valid", o_commit_valid_a, e.valid_a);
        check_value("lane b commit valid", o_commit_valid_b, e.valid_b);
        check_value("lane a write enable", o_commit_we_a, e.we_a);
        check_value("lane b write enable", o_commit_we_b, e.we_b);
        if (e.we_a) begin
            check_value("lane a destination", o_commit_wsel_a, e.wsel_a);
            check_value("lane a data", o_commit_data_a, e.data_a);
        end
        if (e.we_b) begin
            check_value("lane b destination", o_commit_wsel_b, e.wsel_b);
            check_value("lane b data", o_commit_data_b, e.data_b);
        end
        check_value("nzp", o_nzp, e.nzp);
    endtask

    // commit outputs are stable at the falling edge
    always @(negedge gwe) begin : commit_monitor
        commit_t e;
        if (!i_reset && (exp_q.size() != 0) && (exp_q[0].due < cycle_count)) begin
            abort_run("an expected commit never appeared");
        end else if (!i_reset && (o_commit_valid_a || o_commit_valid_b)) begin
            if (exp_q.size() == 0) begin
                abort_run("a commit appeared with nothing issued");
            end else begin
                e = exp_q.pop_front();
                compare_commit(e);
            end
        end
    end

    // model update and expected commits for a pair accepted at this edge
    task automatic expect_pair(insn_t a, insn_t b, int stalls);
        commit_t  e;
        logic     split;
        logic     we_a;
        logic     we_b;
        reg_idx_t rd_a;
        reg_idx_t rd_b;
        word_t    res_a;
        word_t    res_b;
        split = b_reads_a_dest(a, b);
        check_value("cycles with ready low", stalls, split);
        predict(a, we_a, rd_a, res_a);
        apply_write(we_a, rd_a, res_a);
        e = '{due: cycle_count + 1, valid_a: 1'b1, valid_b: 1'b1, we_a: we_a, we_b: 1'b0,
              wsel_a: rd_a, wsel_b: '0, data_a: res_a, data_b: '0, nzp: model_nzp};
        if (split) begin
            // a went alone one cycle before acceptance
            e.due     = cycle_count;
            e.valid_b = 1'b0;
            exp_q.push_back(e);
            e.due     = cycle_count + 1;
            e.valid_a = 1'b0;
            e.valid_b = 1'b1;
        end
        predict(b, we_b, rd_b, res_b);
        apply_write(we_b, rd_b, res_b);
        e.we_a   = e.valid_a && we_a && !(we_b && (rd_b == rd_a));
        e.we_b   = we_b;
        e.wsel_b = rd_b;
        e.data_b = res_b;
        e.nzp    = model_nzp;
        exp_q.push_back(e);
    endtask

    task automatic send_pair(insn_t a, insn_t b);
        int   stalls;
        logic rdy;
        i_insn_a     = a;
        i_insn_b     = b;
        i_pair_valid = 1'b1;
        stalls       = 0;
        rdy          = 1'b0;
        while (!rdy) begin
            @(negedge gwe);
            rdy = o_pair_ready;
            @(posedge gwe);
            #(DRIVE_DLY);
            if (!rdy) begin
                stalls++;
            end
        end
        i_pair_valid = 1'b0;
        expect_pair(a, b, stalls);
    endtask

    task automatic idle_cycles(int n);
        repeat (n) @(posedge gwe);
        #(DRIVE_DLY);
    endtask

    task automatic wait_commits();
        while (exp_q.size() != 0) begin
            @(posedge gwe);
            #(DRIVE_DLY);
        end
    endtask

    task automatic reset_values();
        i_reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge gwe);
        #(DRIVE_DLY);
        i_reset = 1'b0;
        @(negedge gwe);
        check_value("ready right after reset", o_pair_ready, 1'b0);
        check_value("commit valids after reset", {o_commit_valid_a, o_commit_valid_b}, 2'b00);
        check_value("nzp after reset", o_nzp, 3'b000);
        @(negedge gwe);
        check_value("ready one cycle after reset", o_pair_ready, 1'b1);
        for (int i = 0; i < NUM_REGS; i++) begin
            model_regs[i] = 16'h0000;
        end
        model_nzp = 3'b000;
        idle_cycles(1);
    endtask

    task automatic independent_pairs();
        send_pair(const_word(3'd0, 9'd5), const_word(3'd1, 9'h1fd));
        send_pair(const_word(3'd2, 9'd0), const_word(3'd3, 9'h0ff));
        send_pair(rrr_word(OP_ARITH, 3'd4, 3'd0, SUB_ADD, 3'd1),
                  rrr_word(OP_ARITH, 3'd5, 3'd2, SUB_SUB, 3'd3));
        send_pair(rrr_word(OP_LOGIC, 3'd6, 3'd0, SUB_AND, 3'd1),
                  rrr_word(OP_LOGIC, 3'd7, 3'd2, SUB_OR, 3'd3));
        send_pair(rrr_word(OP_LOGIC, 3'd4, 3'd0, SUB_XOR, 3'd1),
                  rrr_word(OP_LOGIC, 3'd5, 3'd3, SUB_NOT, 3'd0));
        send_pair(imm5_word(OP_ARITH, 3'd6, 3'd0, 5'h10), imm5_word(OP_LOGIC, 3'd7, 3'd1, 5'h0a));
        wait_commits();
    endtask

    task automatic dependent_pairs();
        // b reads a's destination through rs, then rt, then both in immediate form
        send_pair(const_word(3'd1, 9'd7), rrr_word(OP_ARITH, 3'd2, 3'd1, SUB_ADD, 3'd1));
        send_pair(rrr_word(OP_ARITH, 3'd3, 3'd0, SUB_SUB, 3'd2),
                  rrr_word(OP_LOGIC, 3'd5, 3'd6, SUB_AND, 3'd3));
        send_pair(imm5_word(OP_ARITH, 3'd6, 3'd6, 5'd1), imm5_word(OP_ARITH, 3'd6, 3'd6, 5'd1));
        wait_commits();
    endtask

    task automatic bypass_chain();
        send_pair(const_word(3'd1, 9'd10), const_word(3'd2, 9'd20));
        send_pair(rrr_word(OP_ARITH, 3'd3, 3'd1, SUB_ADD, 3'd2),
                  rrr_word(OP_ARITH, 3'd4, 3'd2, SUB_SUB, 3'd1));
        // both lanes write r5, the next pair must see lane b's value
        send_pair(const_word(3'd5, 9'd1), const_word(3'd5, 9'h1ff));
        send_pair(rrr_word(OP_ARITH, 3'd6, 3'd5, SUB_ADD, 3'd5),
                  rrr_word(OP_LOGIC, 3'd7, 3'd5, SUB_XOR, 3'd3));
        wait_commits();
    endtask

    task automatic same_dest_pairs();
        send_pair(const_word(3'd1, 9'd10), const_word(3'd2, 9'd20));
        send_pair(rrr_word(OP_ARITH, 3'd0, 3'd1, SUB_ADD, 3'd2),
                  rrr_word(OP_ARITH, 3'd0, 3'd1, SUB_SUB, 3'd2));
        idle_cycles(2);
        // r0 now comes from the register file
        send_pair(rrr_word(OP_ARITH, 3'd3, 3'd0, SUB_ADD, 3'd0), const_word(3'd4, 9'd3));
        send_pair(const_word(3'd4, 9'd0), '0);
        send_pair('0, '0);
        wait_commits();
    endtask

    task automatic random_pairs();
        insn_t       a;
        insn_t       b;
        logic [31:0] r;
        for (int n = 0; n < RANDOM_PAIRS; n++) begin
            a = random_insn();
            b = random_insn();
            send_pair(a, b);
            r = lcg_next();
            if (r[31:29] == 3'd0) begin
                idle_cycles(1);
            end
        end
        wait_commits();
    endtask

    initial begin
        i_reset      = 1'b1;
        i_pair_valid = 1'b0;
        i_insn_a     = '0;
        i_insn_b     = '0;
        reset_values();
        independent_pairs();
        dependent_pairs();
        bypass_chain();
        same_dest_pairs();
        random_pairs();
        $display("sim passed");
        $finish;
    end

endmodule

// ==== lc4_dual_core.f ====
+incdir+verif
src/lc4_core_pkg.sv
src/lc4_isa_pkg.sv
src/lc4_regfile_2w.sv
src/lc4_alu_lane.sv
src/lc4_pair_issue.sv
src/lc4_commit.sv
src/lc4_dual_core.sv
verif/tb_lc4_dual_core.sv

// ==== Bender.yml ====
package:
  name: lc4_dual_core

sources:
  - src/lc4_core_pkg.sv
  - src/lc4_isa_pkg.sv
  - src/lc4_regfile_2w.sv
  - src/lc4_alu_lane.sv
  - src/lc4_pair_issue.sv
  - src/lc4_commit.sv
  - src/lc4_dual_core.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/tb_lc4_dual_core.sv
